/* design/dfe_test_pkg.sv */
/* shared sample, antenna, count and mode types of the DFE test-waveform unit
   imported by the RTL modules and the testbench */
`default_nettype none

package dfe_test_pkg;

   ////////////////////////////////////////////////////////////
   // sample and index widths
   ////////////////////////////////////////////////////////////
   localparam int PRECISION = 16;               // bits per I or Q part

   typedef logic [2*PRECISION-1:0] iq_t;        // {imag, real}, one word
   typedef logic [1:0]             ant_id_t;    // so 1 to 4 antennas
   typedef logic [15:0]            count_t;     // sample count and pointers

   ////////////////////////////////////////////////////////////
   // configuration and controller encodings
   ////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      MODE_IDLE      = 2'd0,                    // unit parked
      MODE_STORE     = 2'd1,                    // capture at next marker
      MODE_PLAY_ONCE = 2'd2,                    // one pass of the block
      MODE_PLAY_LOOP = 2'd3                     // repeat until idle
   } test_mode_t;

   typedef enum logic [1:0] {
      CTRL_IDLE      = 2'd0,
      CTRL_WAIT_MRKR = 2'd1,                    // armed, waiting for frame
      CTRL_STORE     = 2'd2,
      CTRL_PLAY      = 2'd3
   } ctrl_state_t;

endpackage

`default_nettype wire

/* design/dfe_test_ctrl.sv */
/* store/play sequencer: synchronises the async trigger, finds its rising edge
   and broadcasts store/play commands with a start pulse to all buffers */
`timescale 1ns/100ps
`default_nettype none

module dfe_test_ctrl #(
   parameter int N_ANTENNAS = 4
) (
   input  logic                     clk_1x,
   input  logic                     resetn,
   input  dfe_test_pkg::test_mode_t cfg_mode,
   input  logic                     trigger,      // async
   input  logic                     frm_mrkr,     // one-cycle pulse
   input  logic [N_ANTENNAS-1:0]    buf_done,
   output logic                     store_en,
   output logic                     play_en,
   output logic                     play_loop,
   output logic                     cmd_start,
   output logic                     busy
);
   import dfe_test_pkg::*;

   logic        trig_meta;                      // first sync stage
   logic        trig_sync;                      // second sync stage
   logic        trig_prev;                      // delayed copy for edge
   logic        trig_edge;                      // registered rising edge
   logic        all_done;
   logic        mode_idle;
   logic        start_nxt;
   ctrl_state_t state;
   ctrl_state_t state_nxt;

   ////////////////////////////////////////////////////////////
   // trigger synchroniser and edge detect
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_1x) begin
      if (!resetn) begin
         trig_meta <= 1'b0;
         trig_sync <= 1'b0;
         trig_prev <= 1'b0;
         trig_edge <= 1'b0;
      end else begin
         trig_meta <= trigger;
         trig_sync <= trig_meta;
         trig_prev <= trig_sync;
         trig_edge <= trig_sync & ~trig_prev;   // seen 3 cycles after rise
      end
   end

   // done flags are stale in the start cycle, buffers clear them there
   assign all_done  = (&buf_done) & ~cmd_start;
   assign mode_idle = (cfg_mode == MODE_IDLE);

   ////////////////////////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////////////////////////
   always_comb begin
      state_nxt = state;
      start_nxt = 1'b0;
      case (state)
         CTRL_IDLE: begin
            if (trig_edge && (cfg_mode == MODE_STORE)) begin
               state_nxt = CTRL_WAIT_MRKR;      // store waits for frame
            end else if (trig_edge && !mode_idle) begin
               state_nxt = CTRL_PLAY;           // either play mode
               start_nxt = 1'b1;
            end
         end
         CTRL_WAIT_MRKR: begin
            if (mode_idle) begin
               state_nxt = CTRL_IDLE;           // abort, nothing stored
            end else if (frm_mrkr) begin
               state_nxt = CTRL_STORE;
               start_nxt = 1'b1;
            end
         end
         CTRL_STORE, CTRL_PLAY: begin
            if (mode_idle || all_done) begin
               state_nxt = CTRL_IDLE;           // contents are kept
            end
         end
         default: begin
            state_nxt = CTRL_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_1x) begin
      if (!resetn) begin
         state     <= CTRL_IDLE;
         cmd_start <= 1'b0;
      end else begin
         state     <= state_nxt;
         cmd_start <= start_nxt;                // first cycle of store/play
      end
   end

   assign store_en  = (state == CTRL_STORE);
   assign play_en   = (state == CTRL_PLAY);
   assign play_loop = play_en && (cfg_mode == MODE_PLAY_LOOP);
   assign busy      = (state != CTRL_IDLE);

endmodule

`default_nettype wire

/* design/iq_wave_buf.sv */
/* one antenna's waveform memory: captures its own samples from the
   interleaved stream and replays them through a registered valid/ready port */
`timescale 1ns/100ps
`default_nettype none

module iq_wave_buf #(
   parameter int ANT_INDEX = 0,
   parameter int DEPTH     = 64
) (
   input  logic                  clk_1x,
   input  logic                  resetn,
   input  logic                  store_en,
   input  logic                  play_en,
   input  logic                  play_loop,
   input  logic                  cmd_start,      // clears both pointers
   input  dfe_test_pkg::count_t  num_samples,
   input  logic                  s_tvalid,
   input  dfe_test_pkg::iq_t     s_tdata,
   input  dfe_test_pkg::ant_id_t s_tuser,
   input  logic                  buf_ready,
   output logic                  buf_valid,
   output dfe_test_pkg::iq_t     buf_data,
   output logic                  buf_done
);
   import dfe_test_pkg::*;

   localparam int     ADDR_W  = $clog2(DEPTH);
   localparam count_t DEPTH_C = count_t'(DEPTH);

   iq_t    mem [DEPTH];
   count_t limit;                               // clamped sample count
   count_t wr_cnt;
   count_t wr_base;                             // write slot this cycle
   count_t rd_cnt;
   count_t rd_base;                             // read slot this cycle
   count_t rd_next;
   logic   wr_fire;
   logic   rd_fire;
   logic   take;                                // beat accepted downstream
   logic   out_last;                            // output reg holds last sample

   // zero reads as one, anything past the memory as DEPTH
   assign limit = (num_samples == '0)      ? count_t'(1) :
                  (num_samples > DEPTH_C)  ? DEPTH_C     : num_samples;

   assign wr_base = cmd_start ? '0 : wr_cnt;
   assign rd_base = cmd_start ? '0 : rd_cnt;

   assign wr_fire = store_en && s_tvalid && (s_tuser == ant_id_t'(ANT_INDEX)) &&
                    (wr_base < limit);          // full drops the sample
   assign take    = buf_valid && buf_ready;
   assign rd_fire = play_en && (cmd_start || !buf_valid || buf_ready) &&
                    (rd_base < limit);
   assign rd_next = (play_loop && (rd_base + count_t'(1) == limit)) ? '0 :
                    rd_base + count_t'(1);      // wrap only when looping

   ////////////////////////////////////////////////////////////
   // sample memory and output register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_1x) begin
      if (wr_fire) begin
         mem[wr_base[ADDR_W-1:0]] <= s_tdata;
      end
   end

   always_ff @(posedge clk_1x) begin
      if (rd_fire) begin
         buf_data <= mem[rd_base[ADDR_W-1:0]];  // 1 cycle read
         out_last <= (rd_base + count_t'(1) == limit);
      end
   end

   ////////////////////////////////////////////////////////////
   // pointers, valid and done
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_1x) begin
      if (!resetn) begin
         wr_cnt    <= '0;
         rd_cnt    <= '0;
         buf_valid <= 1'b0;
         buf_done  <= 1'b0;
      end else begin
         wr_cnt <= wr_fire ? wr_base + count_t'(1) : wr_base;
         rd_cnt <= rd_fire ? rd_next : rd_base; // moves only on a load
         if (rd_fire) begin
            buf_valid <= 1'b1;
         end else if (take || !play_en) begin
            buf_valid <= 1'b0;
         end
         if (cmd_start) begin
            buf_done <= 1'b0;
         end
         if (wr_fire && (wr_base + count_t'(1) == limit)) begin
            buf_done <= 1'b1;                   // block captured
         end
         if (take && out_last && !play_loop) begin
            buf_done <= 1'b1;                   // play-once finished
         end
      end
   end

endmodule

`default_nettype wire

/* design/ant_interleave.sv */
/* round-robin drain of the per-antenna buffers onto one output stream,
   antenna index carried on the user field */
`timescale 1ns/100ps
`default_nettype none

module ant_interleave #(
   parameter int N_ANTENNAS = 4
) (
   input  logic                  clk_1x,
   input  logic                  resetn,
   input  logic                  cmd_start,      // restart at antenna 0
   input  logic [N_ANTENNAS-1:0] buf_valid,
   input  dfe_test_pkg::iq_t     buf_data [N_ANTENNAS],
   output logic [N_ANTENNAS-1:0] buf_ready,
   input  logic                  m_tready,
   output logic                  m_tvalid,
   output dfe_test_pkg::iq_t     m_tdata,
   output dfe_test_pkg::ant_id_t m_tuser
);
   import dfe_test_pkg::*;

   localparam ant_id_t LAST_ANT = ant_id_t'(N_ANTENNAS - 1);

   ant_id_t sel;                                // antenna being drained
   logic    beat;

   ////////////////////////////////////////////////////////////
   // forward the selected buffer
   ////////////////////////////////////////////////////////////
   assign m_tvalid = buf_valid[sel];
   assign m_tdata  = buf_data[sel];
   assign m_tuser  = sel;
   assign beat     = m_tvalid && m_tready;

   always_comb begin
      buf_ready      = '0;                      // others see no ready
      buf_ready[sel] = m_tready;
   end

   ////////////////////////////////////////////////////////////
   // round-robin pointer
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_1x) begin
      if (!resetn) begin
         sel <= '0;
      end else if (cmd_start) begin
         sel <= '0;                             // every playback from ant 0
      end else if (beat) begin
         if (sel == LAST_ANT) begin
            sel <= '0;
         end else begin
            sel <= sel + ant_id_t'(1);          // next antenna after a beat
         end
      end
   end

endmodule

`default_nettype wire

/* design/dfe_test_gen.sv */
/* top of the DFE test-waveform unit: controller, one buffer per antenna and
   the output interleaver; the radio front end connects here */
`timescale 1ns/100ps
`default_nettype none

module dfe_test_gen #(
   parameter int N_ANTENNAS = 4,
   parameter int DEPTH      = 64
) (
   input  logic                     clk_1x,
   input  logic                     resetn,
   input  dfe_test_pkg::test_mode_t cfg_mode,
   input  dfe_test_pkg::count_t     cfg_num_samples,
   input  logic                     trigger,
   input  logic                     frm_mrkr,
   input  logic                     s_tvalid,
   input  dfe_test_pkg::iq_t        s_tdata,
   input  dfe_test_pkg::ant_id_t    s_tuser,
   output logic                     m_tvalid,
   input  logic                     m_tready,
   output dfe_test_pkg::iq_t        m_tdata,
   output dfe_test_pkg::ant_id_t    m_tuser,
   output logic                     busy
);
   import dfe_test_pkg::*;

   logic                  store_en;
   logic                  play_en;
   logic                  play_loop;
   logic                  cmd_start;
   logic [N_ANTENNAS-1:0] buf_done;
   logic [N_ANTENNAS-1:0] buf_valid;
   logic [N_ANTENNAS-1:0] buf_ready;
   iq_t                   buf_data [N_ANTENNAS];

   ////////////////////////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////////////////////////
   dfe_test_ctrl #(
      .N_ANTENNAS (N_ANTENNAS)
   ) ctrl_i (
      .clk_1x    (clk_1x),
      .resetn    (resetn),
      .cfg_mode  (cfg_mode),
      .trigger   (trigger),
      .frm_mrkr  (frm_mrkr),
      .buf_done  (buf_done),
      .store_en  (store_en),
      .play_en   (play_en),
      .play_loop (play_loop),
      .cmd_start (cmd_start),
      .busy      (busy)
   );

   ////////////////////////////////////////////////////////////
   // per-antenna buffers
   ////////////////////////////////////////////////////////////
   for (genvar g = 0; g < N_ANTENNAS; g++) begin : g_buf
      iq_wave_buf #(
         .ANT_INDEX (g),
         .DEPTH     (DEPTH)
      ) buf_i (
         .clk_1x      (clk_1x),
         .resetn      (resetn),
         .store_en    (store_en),
         .play_en     (play_en),
         .play_loop   (play_loop),
         .cmd_start   (cmd_start),
         .num_samples (cfg_num_samples),
         .s_tvalid    (s_tvalid),
         .s_tdata     (s_tdata),
         .s_tuser     (s_tuser),
         .buf_ready   (buf_ready[g]),
         .buf_valid   (buf_valid[g]),
         .buf_data    (buf_data[g]),
         .buf_done    (buf_done[g])
      );
   end

   ////////////////////////////////////////////////////////////
   // output interleaver
   ////////////////////////////////////////////////////////////
   ant_interleave #(
      .N_ANTENNAS (N_ANTENNAS)
   ) ileave_i (
      .clk_1x    (clk_1x),
      .resetn    (resetn),
      .cmd_start (cmd_start),
      .buf_valid (buf_valid),
      .buf_data  (buf_data),
      .buf_ready (buf_ready),
      .m_tready  (m_tready),
      .m_tvalid  (m_tvalid),
      .m_tdata   (m_tdata),
      .m_tuser   (m_tuser)
   );

endmodule

`default_nettype wire

/* test/dfe_test_gen_assert.sv */
/* bound checks on the output stream and the controller commands,
   attached to every dfe_test_gen instance */
`timescale 1ns/100ps
`default_nettype none

module dfe_test_gen_assert (
   input logic                  clk_1x,
   input logic                  resetn,
   input logic                  m_tvalid,
   input logic                  m_tready,
   input dfe_test_pkg::iq_t     m_tdata,
   input dfe_test_pkg::ant_id_t m_tuser,
   input logic                  store_en,
   input logic                  play_en,
   input logic                  cmd_start
);

   ////////////////////////////////////////////////////////////
   // output stream
   ////////////////////////////////////////////////////////////
   hold_payload: assert property (@(posedge clk_1x) disable iff (!resetn)
      (m_tvalid && !m_tready) |=> ($stable(m_tdata) && $stable(m_tuser)))
      else $error("output payload changed while the beat was stalled");

   quiet_after_reset: assert property (@(posedge clk_1x)
      !resetn |=> !m_tvalid)                    // no beat right out of reset
      else $error("m_tvalid high in the cycle after reset");

   ////////////////////////////////////////////////////////////
   // controller commands
   ////////////////////////////////////////////////////////////
   start_pulse: assert property (@(posedge clk_1x) disable iff (!resetn)
      cmd_start == ($rose(store_en) || $rose(play_en)))   // pulse marks each entry
      else $error("start pulse does not match entry into store or play");

endmodule

bind dfe_test_gen dfe_test_gen_assert assert_i (
   .clk_1x    (clk_1x),
   .resetn    (resetn),
   .m_tvalid  (m_tvalid),
   .m_tready  (m_tready),
   .m_tdata   (m_tdata),
   .m_tuser   (m_tuser),
   .store_en  (store_en),
   .play_en   (play_en),
   .cmd_start (cmd_start)
);

`default_nettype wire

/* test/dfe_test_gen_tb.sv */
/* testbench for dfe_test_gen: applies a table of store and play rows and
   checks every output beat against per-antenna reference queues */
`timescale 1ns/100ps
`default_nettype none

module dfe_test_gen_tb;
   import dfe_test_pkg::*;

   localparam int N_ANT      = 4;
   localparam int DEPTH      = 64;
   localparam int WAIT_LIMIT = 2000;            // cycles for busy to change
   localparam int BEAT_LIMIT = 200;             // cycles without a beat
   localparam int NUM_ROWS   = 10;

   typedef struct packed {
      test_mode_t  mode;
      count_t      num;
      logic [7:0]  junk;                        // samples before the marker
      logic [7:0]  rdy_pct;                     // m_tready chance in percent
      logic [15:0] beats;                       // output beats to check
      logic        abort;                       // drop to idle while armed
   } row_t;

   localparam row_t ROWS [NUM_ROWS] = '{
      '{MODE_STORE,     16'd5,   8'd3, 8'd100, 16'd0,   1'b0},
      '{MODE_PLAY_ONCE, 16'd5,   8'd0, 8'd100, 16'd20,  1'b0},
      '{MODE_PLAY_ONCE, 16'd5,   8'd0, 8'd40,  16'd20,  1'b0},  // heavy back-pressure
      '{MODE_PLAY_LOOP, 16'd5,   8'd0, 8'd70,  16'd40,  1'b0},  // two passes
      '{MODE_STORE,     16'd0,   8'd2, 8'd100, 16'd0,   1'b0},  // zero reads as one
      '{MODE_PLAY_ONCE, 16'd0,   8'd0, 8'd100, 16'd4,   1'b0},
      '{MODE_STORE,     16'd100, 8'd5, 8'd100, 16'd0,   1'b0},  // clamps to DEPTH
      '{MODE_PLAY_ONCE, 16'd100, 8'd0, 8'd60,  16'd256, 1'b0},
      '{MODE_STORE,     16'd7,   8'd4, 8'd100, 16'd0,   1'b1},  // armed, then aborted
      '{MODE_PLAY_ONCE, 16'd100, 8'd0, 8'd100, 16'd256, 1'b0}   // old block expected
   };

   logic       clk_1x = 1'b0;
   logic       resetn;
   test_mode_t cfg_mode;
   count_t     cfg_num_samples;
   logic       trigger;
   logic       frm_mrkr;
   logic       s_tvalid;
   iq_t        s_tdata;
   ant_id_t    s_tuser;
   logic       m_tvalid;
   logic       m_tready;
   iq_t        m_tdata;
   ant_id_t    m_tuser;
   logic       busy;

   iq_t        ref_q [N_ANT][$];                // stored block per antenna
   integer     seed = 32'hce179943;
   int         err_cnt = 0;
   int         tests_run = 0;
   int         tests_failed = 0;
   logic       hung = 1'b0;                     // a wait ran out, stop rows

   always #4 clk_1x = ~clk_1x;                  // 8 ns period

   dfe_test_gen #(
      .N_ANTENNAS (N_ANT),
      .DEPTH      (DEPTH)
   ) dut_i (
      .clk_1x          (clk_1x),
      .resetn          (resetn),
      .cfg_mode        (cfg_mode),
      .cfg_num_samples (cfg_num_samples),
      .trigger         (trigger),
      .frm_mrkr        (frm_mrkr),
      .s_tvalid        (s_tvalid),
      .s_tdata         (s_tdata),
      .s_tuser         (s_tuser),
      .m_tvalid        (m_tvalid),
      .m_tready        (m_tready),
      .m_tdata         (m_tdata),
      .m_tuser         (m_tuser),
      .busy            (busy)
   );

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////
   function automatic int clamp_count(input count_t num);
      if (num == '0) return 1;                  // zero stores one sample
      else if (int'(num) > DEPTH) return DEPTH;
      else return int'(num);
   endfunction

   function automatic logic draw_ready(input logic [7:0] pct);
      int roll;
      roll = $random(seed) & 32'h7fff_ffff;
      return (roll % 100) < int'(pct);
   endfunction

   task automatic send_sample(input ant_id_t ant, input iq_t data);
      @(negedge clk_1x);
      frm_mrkr = 1'b0;                          // marker is one cycle only
      s_tvalid = 1'b1;
      s_tdata  = data;
      s_tuser  = ant;
   endtask

   task automatic start_cmd(input int row_idx, input test_mode_t mode, input count_t num);
      int n;
      @(negedge clk_1x);
      cfg_mode        = mode;
      cfg_num_samples = num;
      trigger         = 1'b1;
      n = 0;
      while (!busy && n < WAIT_LIMIT) begin     // 3 sync cycles plus one
         @(negedge clk_1x);
         n++;
      end
      trigger = 1'b0;
      if (!busy) begin
         $display("row %0d: busy never rose after the trigger", row_idx);
         err_cnt++;
         hung = 1'b1;
      end
   endtask

   task automatic wait_idle(input int row_idx, input string what);
      int n;
      n = 0;
      while (busy && n < WAIT_LIMIT) begin
         @(negedge clk_1x);
         n++;
      end
      if (busy) begin
         $display("row %0d: busy still high %s", row_idx, what);
         err_cnt++;
         hung = 1'b1;
      end
   endtask

   task automatic check_beat(input int row_idx, input int k, input logic loop);
      int  ant;
      int  idx;
      iq_t exp_data;
      ant = k % N_ANT;                          // round robin from antenna 0
      idx = k / N_ANT;
      if (loop && ref_q[ant].size() > 0) idx = idx % ref_q[ant].size();
      if (idx >= ref_q[ant].size()) begin
         $display("row %0d: beat %0d has no stored sample to compare with", row_idx, k);
         err_cnt++;
      end else begin
         exp_data = ref_q[ant][idx];
         if (m_tuser !== ant_id_t'(ant)) begin
            $display("FAIL row %0d beat %0d m_tuser got %h exp %h",
                     row_idx, k, m_tuser, ant_id_t'(ant));
            err_cnt++;
         end
         if (m_tdata !== exp_data) begin
            $display("FAIL row %0d beat %0d m_tdata got %h exp %h",
                     row_idx, k, m_tdata, exp_data);
            err_cnt++;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // row procedures
   ////////////////////////////////////////////////////////////
   task automatic store_block(input int row_idx, input row_t r);
      int      limit;
      ant_id_t ant;
      iq_t     d;
      start_cmd(row_idx, MODE_STORE, r.num);
      for (int j = 0; j < int'(r.junk) && !hung; j++) begin
         send_sample(ant_id_t'(j % N_ANT), iq_t'($random(seed)));   // before marker
      end
      if (!hung && r.abort) begin
         @(negedge clk_1x);
         s_tvalid = 1'b0;
         cfg_mode = MODE_IDLE;                  // leave while still armed
         wait_idle(row_idx, "after dropping to idle while armed");
      end else if (!hung) begin
         @(negedge clk_1x);
         s_tvalid = 1'b0;
         frm_mrkr = 1'b1;
         limit = clamp_count(r.num);
         for (int a = 0; a < N_ANT; a++) ref_q[a].delete();
         for (int i = 0; i < limit * N_ANT + N_ANT; i++) begin   // a few spare
            ant = ant_id_t'(i % N_ANT);
            d   = iq_t'($random(seed));
            if (ref_q[ant].size() < limit) ref_q[ant].push_back(d);
            send_sample(ant, d);
         end
         @(negedge clk_1x);
         s_tvalid = 1'b0;
         wait_idle(row_idx, "after the capture");
      end
   endtask

   task automatic play_block(input int row_idx, input row_t r);
      int   k;
      int   idle;
      logic rdy;
      logic loop;
      loop = (r.mode == MODE_PLAY_LOOP);
      start_cmd(row_idx, r.mode, r.num);
      k    = 0;
      idle = 0;
      while (!hung && k < int'(r.beats)) begin
         @(negedge clk_1x);
         rdy      = draw_ready(r.rdy_pct);
         m_tready = rdy;                        // beat lands on next rising edge
         if (m_tvalid && rdy) begin
            check_beat(row_idx, k, loop);
            k++;
            idle = 0;
         end else if (idle == BEAT_LIMIT) begin
            $display("row %0d: output stalled after %0d beats", row_idx, k);
            err_cnt++;
            hung = 1'b1;
         end else begin
            idle++;
         end
      end
      if (!hung) begin
         @(negedge clk_1x);
         m_tready = 1'b1;
         if (loop) cfg_mode = MODE_IDLE;        // stops the loop
         wait_idle(row_idx, loop ? "after stopping the loop" : "after the last beat");
         repeat (2 * N_ANT) begin
            @(negedge clk_1x);
            if (!loop && m_tvalid) begin
               $display("row %0d: output beat after play-once finished", row_idx);
               err_cnt++;
            end
         end
         m_tready = 1'b0;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      int         errs_before;
      test_mode_t mode;
      resetn          = 1'b0;
      cfg_mode        = MODE_IDLE;
      cfg_num_samples = '0;
      trigger         = 1'b0;
      frm_mrkr        = 1'b0;
      s_tvalid        = 1'b0;
      s_tdata         = '0;
      s_tuser         = '0;
      m_tready        = 1'b0;
      repeat (10) @(posedge clk_1x);
      @(negedge clk_1x);
      resetn = 1'b1;
      @(negedge clk_1x);
      if (m_tvalid !== 1'b0) begin
         $display("FAIL reset m_tvalid got %h exp 0", m_tvalid);
         err_cnt++;
      end
      if (busy !== 1'b0) begin
         $display("FAIL reset busy got %h exp 0", busy);
         err_cnt++;
      end
      tests_run++;
      if (err_cnt != 0) tests_failed++;
      $display("reset state: %s", (err_cnt == 0) ? "ok" : "errors");
      for (int i = 0; i < NUM_ROWS && !hung; i++) begin
         errs_before = err_cnt;
         mode        = ROWS[i].mode;
         if (mode == MODE_STORE) store_block(i, ROWS[i]);
         else play_block(i, ROWS[i]);
         tests_run++;
         if (err_cnt != errs_before) tests_failed++;
         $display("row %0d %s num %0d: %s", i, mode.name(), ROWS[i].num,
                  (err_cnt == errs_before) ? "ok" : "errors");
      end
      $display("tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dfe_test_gen.f */
design/dfe_test_pkg.sv
design/dfe_test_ctrl.sv
design/iq_wave_buf.sv
design/ant_interleave.sv
design/dfe_test_gen.sv
test/dfe_test_gen_assert.sv
test/dfe_test_gen_tb.sv

/* Makefile */
# Verilator build and run of the DFE test-waveform unit testbench
TOP := dfe_test_gen_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f dfe_test_gen.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
